/* tests/hpdcache_patterns.mem */
// Requester 0 columns, then requester 1 columns, each:
// enable write address write_data expected_read_data (zero for write responses)
1 0 00001000 00000000 5a5a1000  0 0 00000000 00000000 00000000
1 0 00001004 00000000 5a5a1004  0 0 00000000 00000000 00000000
0 0 00000000 00000000 00000000  1 0 0000100c 00000000 5a5a100c
1 1 00001008 deadbeef 00000000  0 0 00000000 00000000 00000000
0 0 00000000 00000000 00000000  1 0 00001008 00000000 deadbeef
1 1 00002010 12345678 00000000  0 0 00000000 00000000 00000000
1 0 00002010 00000000 12345678  0 0 00000000 00000000 00000000
0 0 00000000 00000000 00000000  1 0 00002014 00000000 5a5a2014
1 0 00003020 00000000 5a5a3020  0 0 00000000 00000000 00000000
0 0 00000000 00000000 00000000  1 0 00004024 00000000 5a5a4024
1 0 0000302c 00000000 5a5a302c  0 0 00000000 00000000 00000000
0 0 00000000 00000000 00000000  1 0 00004020 00000000 5a5a4020
1 0 00005030 00000000 5a5a5030  1 0 00006040 00000000 5a5a6040
1 0 00005034 00000000 5a5a5034  1 0 00006048 00000000 5a5a6048
1 1 00005038 cafef00d 00000000  1 0 00005038 00000000 cafef00d
1 0 00007050 00000000 5a5a7050  1 1 00007054 0badc0de 00000000
1 0 00008050 00000000 5a5a8050  1 0 00007054 00000000 0badc0de
1 1 00009060 11111111 00000000  1 1 00009064 22222222 00000000
1 0 00009064 00000000 22222222  1 0 00009060 00000000 11111111
1 0 a5a5f0f0 00000000 fffff0f0  1 0 a5a5f0fc 00000000 fffff0fc
1 0 00001008 00000000 deadbeef  1 1 a5a5f0f8 5555aaaa 00000000
1 0 a5a5f0f8 00000000 5555aaaa  0 0 00000000 00000000 00000000

/* build.f */
common/cache_pkg.sv
rtl/req_arbiter.sv
cache_ctrl/cache_dir.sv
cache_ctrl/cache_data.sv
cache_ctrl/cache_ctrl.sv
rtl/miss_handler.sv
rtl/hpdcache_top.sv
tests/tb_hpdcache.sv

/* Makefile */
# Verilator build and run of the shared data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_hpdcache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_hpdcache.sv */
/*
 * Shared data cache testbench
 * Plays request patterns from a file against a memory model with random
 * back-pressure and checks responses, memory reads and memory writes
 */
`timescale 1ns/1ps

module tb_hpdcache import cache_pkg::*; ();

    localparam int NREQ      = 2;
    localparam int NPAT      = 22;
    localparam int COLS      = 5;
    localparam int MAX_CYCLE = NPAT * 200 + 100;

    logic             clk_i;
    logic             rst_n_i;
    logic [NREQ-1:0]  core_req_valid_i;
    logic [NREQ-1:0]  core_req_we_i;
    addr_t [NREQ-1:0] core_req_addr_i;
    word_t [NREQ-1:0] core_req_wdata_i;
    logic [NREQ-1:0]  core_req_ready_o;
    logic [NREQ-1:0]  core_rsp_valid_o;
    word_t            core_rsp_rdata_o;
    logic             mem_rd_req_valid_o;
    logic             mem_rd_req_ready_i;
    addr_t            mem_rd_req_addr_o;
    logic             mem_rd_rsp_valid_i;
    logic             mem_rd_rsp_ready_o;
    word_t            mem_rd_rsp_data_i;
    logic             mem_wr_req_valid_o;
    logic             mem_wr_req_ready_i;
    addr_t            mem_wr_req_addr_o;
    word_t            mem_wr_req_data_o;

    logic [31:0]      pat_mem [NPAT*NREQ*COLS];
    logic [31:0]      lfsr_state;
    int               cycle;
    word_t            model [addr_t];

    // Expected cache contents and memory traffic
    logic             shadow_valid [SETS];
    tag_t             shadow_tag [SETS];
    addr_t            exp_rd_line [$];
    addr_t            exp_wr_addr [$];
    word_t            exp_wr_data [$];

    addr_t            rd_line;
    int               beats_left;
    int               beat_idx;
    logic             beat_hold;
    logic [NREQ-1:0]  want;
    logic [NREQ-1:0]  rsp_wait;
    logic [NREQ-1:0]  exp_hit;
    logic             next_we [NREQ];
    addr_t            next_addr [NREQ];
    word_t            next_wdata [NREQ];
    word_t            exp_rdata [NREQ];
    int               acc_cycle [NREQ];

    hpdcache_top #(.NREQUESTERS(NREQ)) dut_i (
        .clk_i, .rst_n_i,
        .core_req_valid_i, .core_req_we_i, .core_req_addr_i, .core_req_wdata_i,
        .core_req_ready_o, .core_rsp_valid_o, .core_rsp_rdata_o,
        .mem_rd_req_valid_o, .mem_rd_req_ready_i, .mem_rd_req_addr_o,
        .mem_rd_rsp_valid_i, .mem_rd_rsp_ready_o, .mem_rd_rsp_data_i,
        .mem_wr_req_valid_o, .mem_wr_req_ready_i, .mem_wr_req_addr_o, .mem_wr_req_data_o
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic take_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    // Words never written hold a pattern of their own address
    function automatic word_t mem_word(addr_t addr);
        if (model.exists(addr)) begin
            return model[addr];
        end
        return addr ^ 32'h5a5a_0000;
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic sample_outputs();
        if (mem_rd_req_valid_o && mem_rd_req_ready_i) begin
            if (exp_rd_line.size() == 0) begin
                fail_run("Memory read issued for a line that should hit");
            end
            check_value("mem_rd_req_addr_o", mem_rd_req_addr_o, exp_rd_line.pop_front());
            rd_line    = mem_rd_req_addr_o;
            beats_left = LINE_WORDS;
            beat_idx   = 0;
        end
        beat_hold = mem_rd_rsp_valid_i && !mem_rd_rsp_ready_o;
        if (mem_rd_rsp_valid_i && mem_rd_rsp_ready_o) begin
            beats_left--;
            beat_idx++;
        end
        if (mem_wr_req_valid_o && mem_wr_req_ready_i) begin
            if (exp_wr_addr.size() == 0) begin
                fail_run("Memory write issued with no write request pending");
            end
            check_value("mem_wr_req_addr_o", mem_wr_req_addr_o, exp_wr_addr.pop_front());
            check_value("mem_wr_req_data_o", mem_wr_req_data_o, exp_wr_data.pop_front());
            model[mem_wr_req_addr_o] = mem_wr_req_data_o;
        end
        for (int i = 0; i < NREQ; i++) begin
            if (core_req_valid_i[i] && core_req_ready_o[i]) begin
                want[i]      = 1'b0;
                acc_cycle[i] = cycle;
            end
            if (core_rsp_valid_o[i]) begin
                if (!rsp_wait[i] || want[i]) begin
                    fail_run($sformatf("Response on requester %0d with no request taken", i));
                end
                if (i == 1 && rsp_wait[0]) begin
                    fail_run("Requester 1 answered before requester 0");
                end
                check_value("core_rsp_rdata_o", core_rsp_rdata_o, exp_rdata[i]);
                if (exp_hit[i]) begin
                    check_value("core_rsp_valid_o delay", 32'(cycle - acc_cycle[i]), 32'd1);
                end
                rsp_wait[i] = 1'b0;
            end
        end
    endtask

    // Drive on the falling edge and sample mid cycle
    task automatic tick();
        logic offer;
        @(negedge clk_i);
        cycle++;
        if (cycle > MAX_CYCLE) begin
            fail_run("Timeout: a request never got its response");
        end
        mem_rd_req_ready_i = take_bit();
        mem_wr_req_ready_i = take_bit();
        offer = take_bit();
        if (!beat_hold) begin
            mem_rd_rsp_valid_i = offer && (beats_left > 0);
            mem_rd_rsp_data_i  = mem_word(rd_line + addr_t'(4 * beat_idx));
        end
        for (int i = 0; i < NREQ; i++) begin
            core_req_valid_i[i] = want[i];
            core_req_we_i[i]    = next_we[i];
            core_req_addr_i[i]  = next_addr[i];
            core_req_wdata_i[i] = next_wdata[i];
        end
        #1;
        sample_outputs();
    endtask

    task automatic run_pattern(int p);
        int    base;
        set_t  set_idx;
        tag_t  line_tag;
        addr_t addr;
        base = p * NREQ * COLS;
        // Requester 0 is served first, so its effect on the cache comes first
        for (int i = 0; i < NREQ; i++) begin
            addr          = pat_mem[base + i * COLS + 2];
            next_we[i]    = pat_mem[base + i * COLS + 1][0];
            next_addr[i]  = addr;
            next_wdata[i] = pat_mem[base + i * COLS + 3];
            exp_rdata[i]  = pat_mem[base + i * COLS + 4];
            exp_hit[i]    = 1'b0;
            if (pat_mem[base + i * COLS] != 0) begin
                want[i]     = 1'b1;
                rsp_wait[i] = 1'b1;
                set_idx     = addr[OFFSET_W +: SET_W];
                line_tag    = addr[OFFSET_W + SET_W +: TAG_W];
                if (next_we[i]) begin
                    exp_wr_addr.push_back(addr);
                    exp_wr_data.push_back(next_wdata[i]);
                end else if (shadow_valid[set_idx] && shadow_tag[set_idx] == line_tag) begin
                    exp_hit[i] = 1'b1;
                end else begin
                    exp_rd_line.push_back({addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
                    shadow_valid[set_idx] = 1'b1;
                    shadow_tag[set_idx]   = line_tag;
                end
            end
        end
        while (rsp_wait != '0) begin
            tick();
        end
        if (exp_rd_line.size() != 0 || exp_wr_addr.size() != 0) begin
            fail_run($sformatf("Pattern %0d ended with expected memory traffic missing", p));
        end
    endtask

    initial begin
        lfsr_state         = 32'h1cbe_a0ce;
        cycle              = 0;
        rst_n_i            = 1'b0;
        // Requests present during reset must not be taken
        core_req_valid_i   = '1;
        core_req_we_i      = '0;
        core_req_addr_i    = '0;
        core_req_wdata_i   = '0;
        mem_rd_req_ready_i = 1'b0;
        mem_rd_rsp_valid_i = 1'b0;
        mem_rd_rsp_data_i  = '0;
        mem_wr_req_ready_i = 1'b0;
        rd_line            = '0;
        beats_left         = 0;
        beat_idx           = 0;
        beat_hold          = 1'b0;
        want               = '0;
        rsp_wait           = '0;
        exp_hit            = '0;
        for (int s = 0; s < SETS; s++) begin
            shadow_valid[s] = 1'b0;
            shadow_tag[s]   = '0;
        end
        for (int i = 0; i < NREQ; i++) begin
            next_we[i]    = 1'b0;
            next_addr[i]  = '0;
            next_wdata[i] = '0;
            exp_rdata[i]  = '0;
            acc_cycle[i]  = 0;
        end
        $readmemh("tests/hpdcache_patterns.mem", pat_mem);

        repeat (8) @(negedge clk_i);
        check_value("core_req_ready_o", 32'(core_req_ready_o), 32'h0);
        check_value("core_rsp_valid_o", 32'(core_rsp_valid_o), 32'h0);
        check_value("mem_rd_req_valid_o", 32'(mem_rd_req_valid_o), 32'h0);
        check_value("mem_rd_rsp_ready_o", 32'(mem_rd_rsp_ready_o), 32'h0);
        check_value("mem_wr_req_valid_o", 32'(mem_wr_req_valid_o), 32'h0);
        core_req_valid_i = '0;
        rst_n_i          = 1'b1;

        for (int p = 0; p < NPAT; p++) begin
            run_pattern(p);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

/* rtl/hpdcache_top.sv */
/*
 * Shared data cache top
 * Direct-mapped write-through cache for up to four requesters
 */
`timescale 1ns/1ps

module hpdcache_top import cache_pkg::*; #(
    parameter int NREQUESTERS = 2
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic [NREQUESTERS-1:0]  core_req_valid_i,
    input  logic [NREQUESTERS-1:0]  core_req_we_i,
    input  addr_t [NREQUESTERS-1:0] core_req_addr_i,
    input  word_t [NREQUESTERS-1:0] core_req_wdata_i,
    output logic [NREQUESTERS-1:0]  core_req_ready_o,

    output logic [NREQUESTERS-1:0]  core_rsp_valid_o,
    output word_t                   core_rsp_rdata_o,

    output logic                    mem_rd_req_valid_o,
    input  logic                    mem_rd_req_ready_i,
    output addr_t                   mem_rd_req_addr_o,
    input  logic                    mem_rd_rsp_valid_i,
    output logic                    mem_rd_rsp_ready_o,
    input  word_t                   mem_rd_rsp_data_i,

    output logic                    mem_wr_req_valid_o,
    input  logic                    mem_wr_req_ready_i,
    output addr_t                   mem_wr_req_addr_o,
    output word_t                   mem_wr_req_data_o
);

    logic      arb_valid, arb_ready, arb_we;
    sid_t      arb_sid;
    addr_t     arb_addr;
    word_t     arb_wdata;

    logic      dir_rd, dir_valid, dir_wr;
    set_t      dir_rd_set, dir_wr_set;
    tag_t      dir_tag, dir_wr_tag;

    logic      data_rd, data_wr, refill_wr;
    set_t      data_set, refill_set;
    word_sel_t data_word, refill_word;
    word_t     data_wdata, data_rdata, refill_wdata;

    logic      refill_start, refill_done;
    nline_t    refill_nline;

    req_arbiter #(.NREQUESTERS(NREQUESTERS)) req_arbiter_i (
        .clk_i, .rst_n_i,
        .req_valid_i (core_req_valid_i), .req_we_i   (core_req_we_i),
        .req_addr_i  (core_req_addr_i),  .req_wdata_i (core_req_wdata_i),
        .req_ready_o (core_req_ready_o),
        .arb_valid_o (arb_valid), .arb_ready_i (arb_ready), .arb_sid_o (arb_sid),
        .arb_we_o    (arb_we),    .arb_addr_o  (arb_addr),  .arb_wdata_o (arb_wdata)
    );

    cache_ctrl #(.NREQUESTERS(NREQUESTERS)) cache_ctrl_i (
        .clk_i, .rst_n_i,
        .arb_valid_i (arb_valid), .arb_ready_o (arb_ready), .arb_sid_i (arb_sid),
        .arb_we_i    (arb_we),    .arb_addr_i  (arb_addr),  .arb_wdata_i (arb_wdata),
        .dir_rd_o    (dir_rd),    .dir_set_o   (dir_rd_set),
        .dir_valid_i (dir_valid), .dir_tag_i   (dir_tag),
        .data_rd_o   (data_rd),   .data_wr_o   (data_wr),   .data_set_o (data_set),
        .data_word_o (data_word), .data_wdata_o (data_wdata), .data_rdata_i (data_rdata),
        .refill_start_o (refill_start), .refill_nline_o (refill_nline),
        .refill_done_i  (refill_done),
        .mem_wr_req_valid_o, .mem_wr_req_ready_i, .mem_wr_req_addr_o, .mem_wr_req_data_o,
        .core_rsp_valid_o, .core_rsp_rdata_o
    );

    cache_dir cache_dir_i (
        .clk_i, .rst_n_i,
        .rd_i     (dir_rd),     .rd_set_i (dir_rd_set),
        .rd_valid_o (dir_valid), .rd_tag_o (dir_tag),
        .wr_i     (dir_wr),     .wr_set_i (dir_wr_set), .wr_tag_i (dir_wr_tag)
    );

    cache_data cache_data_i (
        .clk_i,
        .rd_i     (data_rd),    .wr_i    (data_wr),     .set_i   (data_set),
        .word_i   (data_word),  .wdata_i (data_wdata),  .rdata_o (data_rdata),
        .refill_wr_i   (refill_wr),   .refill_set_i   (refill_set),
        .refill_word_i (refill_word), .refill_wdata_i (refill_wdata)
    );

    miss_handler miss_handler_i (
        .clk_i, .rst_n_i,
        .refill_start_i (refill_start), .refill_nline_i (refill_nline),
        .refill_done_o  (refill_done),
        .mem_rd_req_valid_o, .mem_rd_req_ready_i, .mem_rd_req_addr_o,
        .mem_rd_rsp_valid_i, .mem_rd_rsp_ready_o, .mem_rd_rsp_data_i,
        .data_wr_o   (refill_wr),   .data_set_o   (refill_set),
        .data_word_o (refill_word), .data_wdata_o (refill_wdata),
        .dir_wr_o    (dir_wr),      .dir_set_o    (dir_wr_set), .dir_tag_o (dir_wr_tag)
    );

endmodule

/* rtl/miss_handler.sv */
/*
 * Miss handler
 * Reads a whole line from memory, writes the beats into the data array
 * and then sets the directory entry
 */
`timescale 1ns/1ps

module miss_handler import cache_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  logic      refill_start_i,
    input  nline_t    refill_nline_i,
    output logic      refill_done_o,

    output logic      mem_rd_req_valid_o,
    input  logic      mem_rd_req_ready_i,
    output addr_t     mem_rd_req_addr_o,

    input  logic      mem_rd_rsp_valid_i,
    output logic      mem_rd_rsp_ready_o,
    input  word_t     mem_rd_rsp_data_i,

    output logic      data_wr_o,
    output set_t      data_set_o,
    output word_sel_t data_word_o,
    output word_t     data_wdata_o,

    output logic      dir_wr_o,
    output set_t      dir_set_o,
    output tag_t      dir_tag_o
);

    typedef enum logic [1:0] {
        MH_IDLE,
        MH_REQ,
        MH_BEATS,
        MH_DIR
    } mh_state_t;

    mh_state_t state_q;
    nline_t    nline_q;
    word_sel_t beat_q;
    logic      beat;

    assign beat = (state_q == MH_BEATS) && mem_rd_rsp_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= MH_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                MH_IDLE: begin
                    beat_q <= '0;
                    if (refill_start_i) state_q <= MH_REQ;
                end
                MH_REQ:   if (mem_rd_req_ready_i) state_q <= MH_BEATS;
                MH_BEATS: begin
                    if (beat) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == word_sel_t'(LINE_WORDS - 1)) state_q <= MH_DIR;
                    end
                end
                MH_DIR:   state_q <= MH_IDLE;
                default:  state_q <= MH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_start_i && (state_q == MH_IDLE)) begin
            nline_q <= refill_nline_i;
        end
    end

    assign mem_rd_req_valid_o = (state_q == MH_REQ);
    assign mem_rd_req_addr_o  = {nline_q, {OFFSET_W{1'b0}}};
    assign mem_rd_rsp_ready_o = (state_q == MH_BEATS);

    // Each accepted beat goes straight into the line
    assign data_wr_o    = beat;
    assign data_set_o   = nline_q[SET_W-1:0];
    assign data_word_o  = beat_q;
    assign data_wdata_o = mem_rd_rsp_data_i;

    assign dir_wr_o      = (state_q == MH_DIR);
    assign dir_set_o     = nline_q[SET_W-1:0];
    assign dir_tag_o     = nline_q[SET_W +: TAG_W];
    assign refill_done_o = (state_q == MH_DIR);

endmodule

/* cache_ctrl/cache_ctrl.sv */
/*
 * Cache controller
 * Looks up each request, answers read hits, starts refills on read misses,
 * sends writes through to memory and routes responses by source id
 */
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
    parameter int NREQUESTERS = 2
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   arb_valid_i,
    output logic                   arb_ready_o,
    input  sid_t                   arb_sid_i,
    input  logic                   arb_we_i,
    input  addr_t                  arb_addr_i,
    input  word_t                  arb_wdata_i,

    output logic                   dir_rd_o,
    output set_t                   dir_set_o,
    input  logic                   dir_valid_i,
    input  tag_t                   dir_tag_i,

    output logic                   data_rd_o,
    output logic                   data_wr_o,
    output set_t                   data_set_o,
    output word_sel_t              data_word_o,
    output word_t                  data_wdata_o,
    input  word_t                  data_rdata_i,

    output logic                   refill_start_o,
    output nline_t                 refill_nline_o,
    input  logic                   refill_done_i,

    output logic                   mem_wr_req_valid_o,
    input  logic                   mem_wr_req_ready_i,
    output addr_t                  mem_wr_req_addr_o,
    output word_t                  mem_wr_req_data_o,

    output logic [NREQUESTERS-1:0] core_rsp_valid_o,
    output word_t                  core_rsp_rdata_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITE,
        ST_REFILL_WAIT,
        ST_REPLAY
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   ready_q;
    logic   wr_rsp_q;
    logic   wr_hit_q;
    sid_t   sid_q;
    logic   we_q;
    addr_t  addr_q;
    word_t  wdata_q;
    logic   accept;
    logic   hit;
    logic   rd_rsp;
    logic   rsp_valid;

    assign arb_ready_o = ready_q;
    assign accept      = (state_q == ST_IDLE) && arb_valid_i && ready_q;
    assign hit         = dir_valid_i && (dir_tag_i == addr_tag(addr_q));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:        if (accept) state_d = ST_LOOKUP;
            ST_LOOKUP: begin
                if (we_q) begin
                    state_d = ST_WRITE;
                end else if (hit) begin
                    state_d = ST_IDLE;
                end else begin
                    state_d = ST_REFILL_WAIT;
                end
            end
            ST_WRITE:       if (mem_wr_req_ready_i) state_d = ST_IDLE;
            ST_REFILL_WAIT: if (refill_done_i) state_d = ST_REPLAY;
            ST_REPLAY:      state_d = ST_LOOKUP;
            default:        state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            ready_q  <= 1'b0;
            wr_rsp_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            ready_q  <= (state_d == ST_IDLE);
            wr_rsp_q <= (state_q == ST_WRITE) && mem_wr_req_ready_i;
        end
    end

    // Request payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            sid_q   <= arb_sid_i;
            we_q    <= arb_we_i;
            addr_q  <= arb_addr_i;
            wdata_q <= arb_wdata_i;
        end
        if (state_q == ST_LOOKUP) begin
            wr_hit_q <= hit;
        end
    end

    // Array reads on acceptance and again on replay
    assign dir_rd_o     = accept || (state_q == ST_REPLAY);
    assign dir_set_o    = (state_q == ST_IDLE) ? addr_set(arb_addr_i) : addr_set(addr_q);
    assign data_rd_o    = dir_rd_o;
    assign data_set_o   = dir_set_o;
    assign data_word_o  = (state_q == ST_IDLE) ? addr_word(arb_addr_i) : addr_word(addr_q);
    assign data_wdata_o = wdata_q;

    // Cache word updated with the memory write on a hit only
    assign data_wr_o    = (state_q == ST_WRITE) && mem_wr_req_ready_i && wr_hit_q;

    assign refill_start_o = (state_q == ST_LOOKUP) && !we_q && !hit;
    assign refill_nline_o = addr_nline(addr_q);

    assign mem_wr_req_valid_o = (state_q == ST_WRITE);
    assign mem_wr_req_addr_o  = addr_q;
    assign mem_wr_req_data_o  = wdata_q;

    assign rd_rsp           = (state_q == ST_LOOKUP) && !we_q && hit;
    assign rsp_valid        = rd_rsp || wr_rsp_q;
    assign core_rsp_rdata_o = rd_rsp ? data_rdata_i : '0;

    always_comb begin
        for (int i = 0; i < NREQUESTERS; i++) begin
            core_rsp_valid_o[i] = rsp_valid && (sid_q == sid_t'(i));
        end
    end

endmodule

/* cache_ctrl/cache_data.sv */
/*
 * Cache data array
 * SETS lines of LINE_WORDS words, written by word from the controller or
 * by refill beats, with a registered read
 */
`timescale 1ns/1ps

module cache_data import cache_pkg::*; (
    input  logic      clk_i,

    input  logic      rd_i,
    input  logic      wr_i,
    input  set_t      set_i,
    input  word_sel_t word_i,
    input  word_t     wdata_i,
    output word_t     rdata_o,

    input  logic      refill_wr_i,
    input  set_t      refill_set_i,
    input  word_sel_t refill_word_i,
    input  word_t     refill_wdata_i
);

    word_t mem_q [SETS][LINE_WORDS];
    word_t rdata_q;

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            mem_q[set_i][word_i] <= wdata_i;
        end
        // Never active together with a core write
        if (refill_wr_i) begin
            mem_q[refill_set_i][refill_word_i] <= refill_wdata_i;
        end
        if (rd_i) begin
            rdata_q <= mem_q[set_i][word_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* cache_ctrl/cache_dir.sv */
/*
 * Cache directory
 * One valid bit and one tag per set, read through an output register
 */
`timescale 1ns/1ps

module cache_dir import cache_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,

    input  logic rd_i,
    input  set_t rd_set_i,
    output logic rd_valid_o,
    output tag_t rd_tag_o,

    input  logic wr_i,
    input  set_t wr_set_i,
    input  tag_t wr_tag_i
);

    logic [SETS-1:0] valid_q;
    tag_t            tags_q [SETS];
    logic            rd_valid_q;
    tag_t            rd_tag_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (wr_i) begin
                valid_q[wr_set_i] <= 1'b1;
            end
            if (rd_i) begin
                rd_valid_q <= valid_q[rd_set_i];
            end
        end
    end

    // Tag storage
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            tags_q[wr_set_i] <= wr_tag_i;
        end
        if (rd_i) begin
            rd_tag_q <= tags_q[rd_set_i];
        end
    end

    assign rd_valid_o = rd_valid_q;
    assign rd_tag_o   = rd_tag_q;

endmodule

/* rtl/req_arbiter.sv */
/*
 * Requester arbiter
 * Fixed priority with the lowest index winning. The grant is held until the
 * request is taken. Multiplexes the winning request toward the controller
 */
`timescale 1ns/1ps

module req_arbiter import cache_pkg::*; #(
    parameter int NREQUESTERS = 2
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic [NREQUESTERS-1:0]  req_valid_i,
    input  logic [NREQUESTERS-1:0]  req_we_i,
    input  addr_t [NREQUESTERS-1:0] req_addr_i,
    input  word_t [NREQUESTERS-1:0] req_wdata_i,
    output logic [NREQUESTERS-1:0]  req_ready_o,

    output logic                    arb_valid_o,
    input  logic                    arb_ready_i,
    output sid_t                    arb_sid_o,
    output logic                    arb_we_o,
    output addr_t                   arb_addr_o,
    output word_t                   arb_wdata_o
);

    logic held_q;
    sid_t held_sid_q;
    sid_t prio_sid;
    sid_t win_sid;

    always_comb begin
        prio_sid = '0;
        for (int i = NREQUESTERS - 1; i >= 0; i--) begin
            if (req_valid_i[i]) begin
                prio_sid = sid_t'(i);
            end
        end
    end

    // A pending grant keeps its winner
    assign win_sid     = held_q ? held_sid_q : prio_sid;
    assign arb_valid_o = |req_valid_i;
    assign arb_sid_o   = win_sid;

    // Payload of the granted requester
    always_comb begin
        arb_we_o    = 1'b0;
        arb_addr_o  = '0;
        arb_wdata_o = '0;
        for (int i = 0; i < NREQUESTERS; i++) begin
            if (win_sid == sid_t'(i)) begin
                arb_we_o    = req_we_i[i];
                arb_addr_o  = req_addr_i[i];
                arb_wdata_o = req_wdata_i[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NREQUESTERS; i++) begin
            req_ready_o[i] = arb_ready_i && arb_valid_o && (win_sid == sid_t'(i));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            held_q     <= 1'b0;
            held_sid_q <= '0;
        end else begin
            held_q     <= arb_valid_o && !arb_ready_i;
            held_sid_q <= win_sid;
        end
    end

endmodule

/* common/cache_pkg.sv */
/*
 * Data cache package
 * Geometry of the direct-mapped cache and the address, data and id types
 * shared by the controller, the arrays and the miss handler
 */
package cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int SETS       = 16;

    // Derived address fields
    localparam int OFFSET_W   = $clog2(LINE_WORDS * (WORD_W / 8));
    localparam int SET_W      = $clog2(SETS);
    localparam int TAG_W      = ADDR_W - SET_W - OFFSET_W;
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);
    localparam int BYTE_SEL_W = OFFSET_W - WORD_SEL_W;

    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [SET_W-1:0]         set_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [WORD_SEL_W-1:0]    word_sel_t;
    typedef logic [TAG_W+SET_W-1:0]   nline_t;

    // Wide enough for at most four requesters
    typedef logic [1:0]               sid_t;

    function automatic set_t addr_set(addr_t addr);
        return addr[OFFSET_W +: SET_W];
    endfunction

    function automatic tag_t addr_tag(addr_t addr);
        return addr[OFFSET_W+SET_W +: TAG_W];
    endfunction

    function automatic word_sel_t addr_word(addr_t addr);
        return addr[BYTE_SEL_W +: WORD_SEL_W];
    endfunction

    function automatic nline_t addr_nline(addr_t addr);
        return addr[OFFSET_W +: TAG_W+SET_W];
    endfunction

endpackage
